// ==== test/pov_stimulus.txt ====
# Columns: test name, check kind, frame length in bytes, frame bytes in hex (opcode first),
# expected value in hex (config word, column words chain 0 first, row or last_op and bad_frames)

# Driver configuration word
cfg_load      cfg    7   01a5c30f1e2d3c  a5c30f1e2d3c

# Column data, then one frame with the display on
col_load      none   25  02123456789abcfedcba9876540f0f0f0ff0f0800000000001  0
scan_on       scan   2   0301  123456789abcfedcba9876540f0f0f0ff0f0800000000001

# Blanked display sends zero words
blank_off     blank  2   0300  0

# Row multiplexer override and release
mux_manual    mux    3   0401a5  a5
mux_auto      row    3   040000  01

# Wrong length column, unknown opcode, then a status command
bad_len       none   5   0211223344  0
bad_op        none   1   7f  0
status_op     none   1   05  0

# Status read back during config frames
status_read1  stat   7   01a5c30f1e2d3c  0502
status_read2  stat   7   01a5c30f1e2d3c  0102

// ==== tb.f ====
src/pov_pkg.sv
src/frame_timer.sv
src/spi_iff.sv
src/spi_decoder.sv
src/driver_controller.sv
src/pov_top.sv
test/tb_pov_top.sv

// ==== Bender.yml ====
package:
  name: pov_display

sources:
  - src/pov_pkg.sv
  - src/frame_timer.sv
  - src/spi_iff.sv
  - src/spi_decoder.sv
  - src/driver_controller.sv
  - src/pov_top.sv
  - target: test
    files:
      - test/tb_pov_top.sv

// ==== test/tb_pov_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pov_top import pov_pkg::*; ();

    localparam int NUM_CHAINS   = 4;
    localparam int NUM_COLS     = 8;
    localparam int CLK_DIV      = 2;
    localparam int FRAME_PERIOD = 2048;
    // SPI half period in clk cycles, 8 clk per bit
    localparam int HALF_BIT     = 4;
    localparam int XFER_BITS    = CHAIN_BITS + 1;
    localparam int HIST         = 128;
    // Six revolutions of driver activity plus SPI traffic
    localparam int TIMEOUT_CYCLES = 6 * FRAME_PERIOD * CLK_DIV + 20000;

    logic                  clk;
    logic                  rst_n;
    logic                  spi_clk;
    logic                  spi_cs_n;
    logic                  spi_mosi;
    logic                  spi_miso;
    logic                  drv_gclk;
    logic                  drv_sclk;
    logic                  drv_lat;
    logic [NUM_CHAINS-1:0] drv_sin;
    logic [7:0]            row_sel;

    // Driver chain capture
    logic [NUM_CHAINS-1:0][XFER_BITS-1:0] cap;
    logic [NUM_CHAINS-1:0][XFER_BITS-1:0] words [HIST];
    logic [7:0]                           rows [HIST];
    logic                                 sclk_q;
    logic                                 lat_q;
    int                                   lat_count;
    int                                   sof_count;
    int                                   gclk_hi_count;
    int                                   cycle;
    int                                   fail_count;
    int                                   test_count;

    pov_top #(
        .NUM_CHAINS   (NUM_CHAINS),
        .NUM_COLS     (NUM_COLS),
        .CLK_DIV      (CLK_DIV),
        .FRAME_PERIOD (FRAME_PERIOD)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_clk  (spi_clk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .drv_gclk (drv_gclk),
        .drv_sclk (drv_sclk),
        .drv_lat  (drv_lat),
        .drv_sin  (drv_sin),
        .row_sel  (row_sel)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit
    initial begin
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", cycle);
        $display("STATUS: FAIL");
        $finish;
    end

    // Sin taken on each sclk rise, word stored when lat rises
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_q        <= 1'b0;
            lat_q         <= 1'b0;
            lat_count     <= 0;
            sof_count     <= 0;
            gclk_hi_count <= 0;
        end else begin
            sclk_q <= drv_sclk;
            lat_q  <= drv_lat;
            if (drv_sclk && !sclk_q) begin
                for (int c = 0; c < NUM_CHAINS; c++) begin
                    cap[c] <= {cap[c][XFER_BITS-2:0], drv_sin[c]};
                end
            end
            if (drv_lat && !lat_q) begin
                words[lat_count % HIST] <= cap;
                // Row shown while this column is latched
                rows[lat_count % HIST]  <= row_sel;
                lat_count               <= lat_count + 1;
            end
            if (i_dut.sof) begin
                sof_count <= sof_count + 1;
            end
            if (drv_gclk) begin
                gclk_hi_count <= gclk_hi_count + 1;
            end
        end
    end

    // Mode 0 master, MSB first, status collected from MISO
    task automatic spi_xfer(input int len, input logic [199:0] frame, output status_t rx);
        logic [47:0] rx_bits;
        logic [7:0]  tx_byte;
        int          nbits;
        int          gap;
        rx_bits = '0;
        nbits   = 0;
        @(posedge clk);
        spi_cs_n <= 1'b0;
        // Let the status snapshot settle before the first bit
        repeat (2 * HALF_BIT) @(posedge clk);
        for (int i = 0; i < len; i++) begin
            tx_byte = frame[8*(len-1-i) +: 8];
            for (int b = 7; b >= 0; b--) begin
                spi_mosi <= tx_byte[b];
                repeat (HALF_BIT) @(posedge clk);
                // MISO read just before the rising edge
                if (nbits < 48) begin
                    rx_bits = {rx_bits[46:0], spi_miso};
                    nbits++;
                end
                spi_clk <= 1'b1;
                repeat (HALF_BIT) @(posedge clk);
                spi_clk <= 1'b0;
            end
            // Random idle time between bytes
            gap = $urandom % 4;
            repeat (gap) @(posedge clk);
        end
        repeat (2 * HALF_BIT) @(posedge clk);
        spi_cs_n <= 1'b1;
        // Frame strobe and decoder update
        repeat (4 * HALF_BIT) @(posedge clk);
        rx = rx_bits;
    endtask

    task automatic wait_sof();
        int start;
        start = sof_count;
        while (sof_count == start) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_latches(input int target);
        while (lat_count < target) begin
            @(posedge clk);
        end
    endtask

    // Column words are a 0 select bit and then that chain's data
    task automatic check_columns(input logic [8*24-1:0] name, input int base,
                                 input logic [191:0] exp_v);
        logic [XFER_BITS-1:0] want;
        for (int k = 0; k < NUM_COLS; k++) begin
            for (int c = 0; c < NUM_CHAINS; c++) begin
                want = {1'b0, exp_v[CHAIN_BITS*(NUM_CHAINS-1-c) +: CHAIN_BITS]};
                if (words[(base + k) % HIST][c] !== want) begin
                    $display("[FAIL] %0s column %0d chain %0d expected %h actual %h",
                             name, k, c, want, words[(base + k) % HIST][c]);
                    fail_count++;
                end
            end
        end
    endtask

    initial begin
        int                   fd;
        int                   n;
        int                   len;
        int                   base;
        int                   gclk_base;
        int                   errs;
        int                   prev_frame;
        int unsigned          seed;
        logic [8*200-1:0]     line_buf;
        logic [8*24-1:0]      name;
        logic [8*8-1:0]       kind;
        logic [199:0]         frame;
        logic [191:0]         exp_v;
        logic [XFER_BITS-1:0] want;
        status_t              rx;

        seed       = $urandom(32'h20fabd04);
        rst_n      = 1'b0;
        spi_clk    = 1'b0;
        spi_cs_n   = 1'b1;
        spi_mosi   = 1'b0;
        fail_count = 0;
        test_count = 0;
        prev_frame = -1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        fd = $fopen("test/pov_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/pov_stimulus.txt, no tests were run");
            fail_count++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line_buf = '0;
            n = $fgets(line_buf, fd);
            // Comment and blank lines give fewer fields
            n = $sscanf(line_buf, "%s %s %d %h %h", name, kind, len, frame, exp_v);
            if (n == 5) begin
                test_count++;
                errs = fail_count;
                spi_xfer(len, frame, rx);
                if (kind == "cfg") begin
                    base = lat_count;
                    wait_latches(base + 1);
                    want = {1'b1, exp_v[CHAIN_BITS-1:0]};
                    for (int c = 0; c < NUM_CHAINS; c++) begin
                        if (words[base % HIST][c] !== want) begin
                            $display("[FAIL] %0s chain %0d expected %h actual %h",
                                     name, c, want, words[base % HIST][c]);
                            fail_count++;
                        end
                    end
                end else if (kind == "scan") begin
                    // One whole revolution, sof to sof
                    wait_sof();
                    base      = lat_count;
                    gclk_base = gclk_hi_count;
                    wait_sof();
                    if (lat_count - base != NUM_COLS) begin
                        $display("[FAIL] %0s latches per frame expected %0d actual %0d",
                                 name, NUM_COLS, lat_count - base);
                        fail_count++;
                    end
                    // Grayscale clock must run while the display is on
                    if (gclk_hi_count == gclk_base) begin
                        $display("%0s gclk never went high while the display was on", name);
                        fail_count++;
                    end
                    for (int k = 0; k < NUM_COLS; k++) begin
                        if (rows[(base + k) % HIST] !== 8'(1 << k)) begin
                            $display("[FAIL] %0s row of column %0d expected %h actual %h",
                                     name, k, 8'(1 << k), rows[(base + k) % HIST]);
                            fail_count++;
                        end
                    end
                    check_columns(name, base, exp_v);
                end else if (kind == "blank") begin
                    wait_sof();
                    base      = lat_count;
                    gclk_base = gclk_hi_count;
                    wait_latches(base + NUM_COLS);
                    if (gclk_hi_count != gclk_base) begin
                        $display("%0s gclk went high %0d times while the display was blanked",
                                 name, gclk_hi_count - gclk_base);
                        fail_count++;
                    end
                    check_columns(name, base, exp_v);
                end else if (kind == "mux") begin
                    if (row_sel !== exp_v[7:0]) begin
                        $display("[FAIL] %0s row_sel expected %h actual %h",
                                 name, exp_v[7:0], row_sel);
                        fail_count++;
                    end
                end else if (kind == "row") begin
                    // First column of the next frame
                    wait_sof();
                    base = lat_count;
                    wait_latches(base + 1);
                    if (rows[base % HIST] !== exp_v[7:0]) begin
                        $display("[FAIL] %0s row_sel expected %h actual %h",
                                 name, exp_v[7:0], rows[base % HIST]);
                        fail_count++;
                    end
                end else if (kind == "stat") begin
                    if ({rx.last_op, rx.bad_frames} !== exp_v[15:0]) begin
                        $display("[FAIL] %0s last_op/bad_frames expected %h actual %h",
                                 name, exp_v[15:0], {rx.last_op, rx.bad_frames});
                        fail_count++;
                    end
                    if (prev_frame >= 0 && int'(rx.frame_count) < prev_frame) begin
                        $display("%0s frame count went back from %0d to %0d",
                                 name, prev_frame, rx.frame_count);
                        fail_count++;
                    end
                    prev_frame = int'(rx.frame_count);
                end
                if (fail_count == errs) begin
                    $display("[PASS] %0s", name);
                end else begin
                    $display("[DONE] %0s with %0d failed checks", name, fail_count - errs);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("%0d tests run, %0d checks failed", test_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/pov_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pov_top import pov_pkg::*; #(
    parameter int NUM_CHAINS   = 4,
    parameter int NUM_COLS     = 8,
    parameter int CLK_DIV      = 2,
    parameter int FRAME_PERIOD = 2048
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // SPI from the host SoC
    input  logic                  spi_clk,
    input  logic                  spi_cs_n,
    input  logic                  spi_mosi,
    output logic                  spi_miso,
    // LED driver chains
    output logic                  drv_gclk,
    output logic                  drv_sclk,
    output logic                  drv_lat,
    output logic [NUM_CHAINS-1:0] drv_sin,
    output logic [7:0]            row_sel
);

    logic                         clk_en;
    logic                         sof;
    logic [15:0]                  frame_count;
    frame_buf_t                   frame_data;
    frame_len_t                   frame_len;
    logic                         frame_valid;
    status_t                      status;
    drv_cfg_t                     cfg;
    logic                         cfg_new;
    chain_word_t [NUM_CHAINS-1:0] column_data;
    logic                         display_en;
    mux_ctrl_t                    mux_ctrl;
    logic [15:0]                  column;

    // Enable divider and Hall sensor stand-in
    frame_timer #(
        .CLK_DIV      (CLK_DIV),
        .FRAME_PERIOD (FRAME_PERIOD)
    ) i_frame_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_en      (clk_en),
        .sof         (sof),
        .frame_count (frame_count)
    );

    spi_iff i_spi_iff (
        .clk         (clk),
        .rst_n       (rst_n),
        .spi_clk     (spi_clk),
        .spi_cs_n    (spi_cs_n),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .status      (status),
        .frame_data  (frame_data),
        .frame_len   (frame_len),
        .frame_valid (frame_valid)
    );

    spi_decoder #(
        .NUM_CHAINS (NUM_CHAINS)
    ) i_spi_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_data  (frame_data),
        .frame_len   (frame_len),
        .frame_valid (frame_valid),
        .frame_count (frame_count),
        .column      (column),
        .status      (status),
        .cfg         (cfg),
        .cfg_new     (cfg_new),
        .column_data (column_data),
        .display_en  (display_en),
        .mux_ctrl    (mux_ctrl)
    );

    driver_controller #(
        .NUM_CHAINS (NUM_CHAINS),
        .NUM_COLS   (NUM_COLS)
    ) i_driver_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_en      (clk_en),
        .sof         (sof),
        .cfg         (cfg),
        .cfg_new     (cfg_new),
        .column_data (column_data),
        .display_en  (display_en),
        .mux_ctrl    (mux_ctrl),
        .column      (column),
        .sclk        (drv_sclk),
        .lat         (drv_lat),
        .gclk        (drv_gclk),
        .sin         (drv_sin),
        .row_sel     (row_sel)
    );

endmodule

`default_nettype wire

// ==== src/driver_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module driver_controller import pov_pkg::*; #(
    parameter int NUM_CHAINS = 4,
    parameter int NUM_COLS   = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         clk_en,
    input  logic                         sof,
    input  drv_cfg_t                     cfg,
    input  logic                         cfg_new,
    input  chain_word_t [NUM_CHAINS-1:0] column_data,
    input  logic                         display_en,
    input  mux_ctrl_t                    mux_ctrl,
    output logic [15:0]                  column,
    output logic                         sclk,
    output logic                         lat,
    output logic                         gclk,
    output logic [NUM_CHAINS-1:0]        sin,
    output logic [7:0]                   row_sel
);

    // Leading select bit plus the data word
    localparam int XFER_BITS = CHAIN_BITS + 1;

    drv_state_e                           state;
    logic [NUM_CHAINS-1:0][XFER_BITS-1:0] shift_q;
    logic [5:0]                           bit_cnt;
    logic                                 phase;
    logic                                 lat_cnt;
    logic                                 cfg_pending;
    logic                                 is_cfg;
    logic                                 scan_active;
    logic [15:0]                          col_cnt;
    logic [7:0]                           scan_row;
    logic                                 load_cfg;
    logic                                 load_col;
    logic                                 shift_en;

    // Pending config goes ahead of the next column
    assign load_cfg = clk_en && (state == IDLE) && cfg_pending;
    assign load_col = clk_en && (state == IDLE) && !cfg_pending && scan_active;
    // Word moves on after each sclk high phase
    assign shift_en = clk_en && (state == SHIFT) && phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_pending <= 1'b0;
        end else if (cfg_new) begin
            cfg_pending <= 1'b1;
        end else if (load_cfg) begin
            cfg_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < NUM_CHAINS; c++) begin
            if (load_cfg) begin
                shift_q[c] <= {1'b1, cfg};
            end else if (load_col) begin
                // Blanked display sends zero words
                shift_q[c] <= {1'b0, display_en ? column_data[c] : chain_word_t'(0)};
            end else if (shift_en) begin
                shift_q[c] <= shift_q[c] << 1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            phase       <= 1'b0;
            bit_cnt     <= '0;
            lat_cnt     <= 1'b0;
            is_cfg      <= 1'b0;
            sclk        <= 1'b0;
            lat         <= 1'b0;
            sin         <= '0;
            scan_active <= 1'b0;
            col_cnt     <= '0;
            scan_row    <= '0;
        end else if (clk_en) begin
            case (state)
                IDLE: begin
                    if (load_cfg || load_col) begin
                        is_cfg  <= load_cfg;
                        phase   <= 1'b0;
                        bit_cnt <= '0;
                        state   <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (!phase) begin
                        // Data set up with sclk low
                        sclk <= 1'b0;
                        for (int c = 0; c < NUM_CHAINS; c++) begin
                            sin[c] <= shift_q[c][XFER_BITS-1];
                        end
                        phase <= 1'b1;
                    end else begin
                        sclk    <= 1'b1;
                        phase   <= 1'b0;
                        bit_cnt <= bit_cnt + 6'd1;
                        if (bit_cnt == 6'(XFER_BITS - 1)) begin
                            lat_cnt <= 1'b0;
                            state   <= LATCH;
                        end
                    end
                end
                LATCH: begin
                    // Two enables of lat high with sclk parked low
                    sclk    <= 1'b0;
                    lat     <= 1'b1;
                    sin     <= '0;
                    lat_cnt <= 1'b1;
                    if (lat_cnt) begin
                        state <= NEXT;
                    end
                end
                NEXT: begin
                    lat <= 1'b0;
                    if (!is_cfg) begin
                        scan_row <= scan_row << 1;
                        col_cnt  <= col_cnt + 16'd1;
                        if (col_cnt == 16'(NUM_COLS - 1)) begin
                            scan_active <= 1'b0;
                        end
                    end
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
            // New revolution restarts the scan at row 0
            if (sof) begin
                scan_active <= 1'b1;
                col_cnt     <= '0;
                scan_row    <= 8'd1;
            end
        end
    end

    // Grayscale clock runs only while the display is on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gclk <= 1'b0;
        end else if (clk_en) begin
            gclk <= display_en ? ~gclk : 1'b0;
        end
    end

    assign column  = col_cnt;
    assign row_sel = mux_ctrl.manual ? mux_ctrl.row : scan_row;

    // Latch must never overlap a shift clock pulse
    assert property (@(posedge clk) disable iff (!rst_n) !(lat && sclk))
        else $error("lat and sclk high together");

endmodule

`default_nettype wire

// ==== src/spi_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_decoder import pov_pkg::*; #(
    parameter int NUM_CHAINS = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  frame_buf_t                   frame_data,
    input  frame_len_t                   frame_len,
    input  logic                         frame_valid,
    input  logic [15:0]                  frame_count,
    input  logic [15:0]                  column,
    output status_t                      status,
    output drv_cfg_t                     cfg,
    output logic                         cfg_new,
    output chain_word_t [NUM_CHAINS-1:0] column_data,
    output logic                         display_en,
    output mux_ctrl_t                    mux_ctrl
);

    localparam int         WORD_BYTES = CHAIN_BITS / 8;
    // Opcode plus one full word per chain
    localparam frame_len_t COL_LEN    = frame_len_t'(1 + NUM_CHAINS * WORD_BYTES);

    opcode_t                      opcode;
    frame_len_t                   need_len;
    logic                         known_op;
    logic                         good_frame;
    logic                         cfg_hit;
    opcode_t                      last_op;
    logic [7:0]                   bad_frames;
    drv_cfg_t                     cfg_word;
    chain_word_t [NUM_CHAINS-1:0] col_words;

    assign opcode = frame_data[0];

    // Required length per opcode
    always_comb begin
        known_op = 1'b1;
        case (opcode)
            OP_CONFIG: need_len = LEN_CONFIG;
            OP_COLUMN: need_len = COL_LEN;
            OP_ENABLE: need_len = LEN_ENABLE;
            OP_MUX:    need_len = LEN_MUX;
            OP_STATUS: need_len = LEN_STATUS;
            default: begin
                need_len = '0;
                known_op = 1'b0;
            end
        endcase
    end

    assign good_frame = known_op && (frame_len == need_len);
    assign cfg_hit    = frame_valid && good_frame && (opcode == OP_CONFIG);

    // Payload bytes arrive MSB first, chain 0 first
    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            cfg_word[CHAIN_BITS-1-8*b -: 8] = frame_data[1+b];
        end
        for (int c = 0; c < NUM_CHAINS; c++) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                col_words[c][CHAIN_BITS-1-8*b -: 8] = frame_data[1+c*WORD_BYTES+b];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_new     <= 1'b0;
            display_en  <= 1'b0;
            column_data <= '0;
            mux_ctrl    <= '0;
            last_op     <= '0;
            bad_frames  <= '0;
        end else begin
            cfg_new <= cfg_hit;
            if (frame_valid) begin
                if (good_frame) begin
                    last_op <= opcode;
                    case (opcode)
                        OP_COLUMN: column_data <= col_words;
                        OP_ENABLE: display_en <= frame_data[1][0];
                        OP_MUX: begin
                            mux_ctrl.manual <= frame_data[1][0];
                            mux_ctrl.row    <= frame_data[2];
                        end
                        default: begin
                        end
                    endcase
                end else if (bad_frames != 8'hFF) begin
                    // Saturating error count
                    bad_frames <= bad_frames + 8'd1;
                end
            end
        end
    end

    // Config word lands with the cfg_new strobe
    always_ff @(posedge clk) begin
        if (cfg_hit) begin
            cfg <= cfg_word;
        end
    end

    assign status = '{
        frame_count: frame_count,
        column:      column,
        last_op:     last_op,
        bad_frames:  bad_frames
    };

endmodule

`default_nettype wire

// ==== src/spi_iff.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_iff import pov_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_clk,
    input  logic       spi_cs_n,
    input  logic       spi_mosi,
    output logic       spi_miso,
    input  status_t    status,
    output frame_buf_t frame_data,
    output frame_len_t frame_len,
    output logic       frame_valid
);

    // Two sync flops plus one history flop for edge detection
    logic [2:0]          clk_sync;
    logic [2:0]          cs_sync;
    logic [1:0]          mosi_sync;
    logic                sclk_rise;
    logic                sclk_fall;
    logic                cs_fall;
    logic                cs_rise;
    logic                cs_active;
    logic [2:0]          bit_cnt;
    logic [7:0]          byte_sr;
    logic [7:0]          byte_next;
    logic                byte_done;
    frame_len_t          byte_cnt;
    logic [$bits(status_t)-1:0] miso_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
        end else begin
            clk_sync  <= {clk_sync[1:0], spi_clk};
            cs_sync   <= {cs_sync[1:0], spi_cs_n};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    assign sclk_rise = clk_sync[1] & ~clk_sync[2];
    assign sclk_fall = ~clk_sync[1] & clk_sync[2];
    assign cs_active = ~cs_sync[1];
    assign cs_fall   = ~cs_sync[1] & cs_sync[2];
    assign cs_rise   = cs_sync[1] & ~cs_sync[2];

    // Mode 0, MOSI taken on the rising SPI clock edge
    assign byte_next = {byte_sr[6:0], mosi_sync[1]};
    assign byte_done = cs_active && sclk_rise && (bit_cnt == 3'd7);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            miso_sr     <= '0;
            frame_valid <= 1'b0;
        end else begin
            // Only report frames holding at least one whole byte
            frame_valid <= cs_rise && (byte_cnt != '0);
            if (cs_fall) begin
                bit_cnt  <= '0;
                byte_cnt <= '0;
                // Status snapshot, bit 47 shows right away
                miso_sr  <= status;
            end else if (cs_active) begin
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                end
                // Extra bytes still counted so the decoder sees the bad length
                if (byte_done && byte_cnt != 8'hFF) begin
                    byte_cnt <= byte_cnt + 8'd1;
                end
                if (sclk_fall) begin
                    miso_sr <= {miso_sr[$bits(status_t)-2:0], 1'b0};
                end
            end
        end
    end

    // Byte assembly and frame buffer
    always_ff @(posedge clk) begin
        if (cs_active && sclk_rise) begin
            byte_sr <= byte_next;
        end
        if (byte_done && byte_cnt < frame_len_t'(MAX_FRAME_BYTES)) begin
            frame_data[byte_cnt] <= byte_next;
        end
    end

    assign frame_len = byte_cnt;
    assign spi_miso  = miso_sr[$bits(status_t)-1];

    // One strobe per chip select release
    assert property (@(posedge clk) disable iff (!rst_n) frame_valid |=> !frame_valid)
        else $error("frame_valid held for two cycles");

endmodule

`default_nettype wire

// ==== src/frame_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_timer #(
    parameter int CLK_DIV      = 2,
    parameter int FRAME_PERIOD = 2048
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        clk_en,
    output logic        sof,
    output logic [15:0] frame_count
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int PER_W = (FRAME_PERIOD > 1) ? $clog2(FRAME_PERIOD) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [PER_W-1:0] period_cnt;
    logic             en_next;
    logic             wrap_next;

    // Enable is due once the divider reaches its top
    assign en_next   = (div_cnt == DIV_W'(CLK_DIV - 1));
    // Last enable of the emulated revolution
    assign wrap_next = en_next && (period_cnt == PER_W'(FRAME_PERIOD - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt     <= '0;
            period_cnt  <= '0;
            clk_en      <= 1'b0;
            sof         <= 1'b0;
            frame_count <= '0;
        end else begin
            div_cnt <= en_next ? '0 : div_cnt + 1'b1;
            clk_en  <= en_next;
            // Hall pulse stand-in, registered together with the enable
            sof     <= wrap_next;
            if (en_next) begin
                period_cnt <= wrap_next ? '0 : period_cnt + 1'b1;
            end
            // One count per revolution, wraps at 16 bits
            if (wrap_next) begin
                frame_count <= frame_count + 16'd1;
            end
        end
    end

    // Driver FSM only looks at sof on enabled cycles
    assert property (@(posedge clk) disable iff (!rst_n) sof |-> clk_en)
        else $error("sof raised outside clk_en");

endmodule

`default_nettype wire

// ==== src/pov_pkg.sv ====
`default_nettype none

package pov_pkg;

    // Data bits per driver chain, fixed by the LED driver device
    localparam int CHAIN_BITS = 48;

    typedef logic [CHAIN_BITS-1:0] chain_word_t;
    typedef logic [CHAIN_BITS-1:0] drv_cfg_t;

    // Opcode byte plus the largest payload
    localparam int MAX_FRAME_BYTES = 25;

    typedef logic [7:0] frame_len_t;
    typedef logic [7:0] opcode_t;

    // Byte 0 holds the opcode, payload follows
    typedef logic [MAX_FRAME_BYTES-1:0][7:0] frame_buf_t;

    // Command opcodes
    localparam opcode_t OP_CONFIG = 8'h01;
    localparam opcode_t OP_COLUMN = 8'h02;
    localparam opcode_t OP_ENABLE = 8'h03;
    localparam opcode_t OP_MUX    = 8'h04;
    localparam opcode_t OP_STATUS = 8'h05;

    // Whole frame lengths, opcode byte included
    localparam frame_len_t LEN_CONFIG = 8'd7;
    localparam frame_len_t LEN_ENABLE = 8'd2;
    localparam frame_len_t LEN_MUX    = 8'd3;
    localparam frame_len_t LEN_STATUS = 8'd1;

    // Row multiplexer override
    typedef struct packed {
        logic       manual;
        logic [7:0] row;
    } mux_ctrl_t;

    // Status word, sent MSB first on MISO
    typedef struct packed {
        logic [15:0] frame_count;
        logic [15:0] column;
        opcode_t     last_op;
        logic [7:0]  bad_frames;
    } status_t;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        LATCH,
        NEXT
    } drv_state_e;

endpackage

`default_nettype wire
